// ==== sim.f ====
+incdir+.
ice_app_pkg.sv
spi_cmd_if.sv
spi_link.sv
cmd_exec.sv
cmd6_capture.sv
ice_app.sv
tb_ice_app.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_ice_app -f sim.f -o tb_ice_app \
    > sim.log 2>&1 &&
    ./obj_dir/tb_ice_app >> sim.log 2>&1
grep -qx "Test OK" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== tb_ice_app_table.svh ====
`ifndef TB_ICE_APP_TABLE_SVH
`define TB_ICE_APP_TABLE_SVH

// Columns: op, type, argument, block seed, expected led, response expected,
// response taken from the captured access mode, expected response
typedef enum logic {
    OP_MSG,     // Serial message on the link
    OP_BLOCK    // Data-in block of 32 words
} op_t;

typedef struct packed {
    op_t            op;
    logic [7:0]     msg_type;   // Raw byte so unknown types fit
    msg_arg_t       arg;
    logic [31:0]    blk_seed;   // XOR onto the base seed
    logic [3:0]     exp_led;
    logic           exp_resp;
    logic           mode_resp;
    resp_t          exp_data;
} stim_row_t;

localparam int NUM_ROWS = 15;

stim_row_t stim_tab [NUM_ROWS] = '{
    '{OP_MSG,   MSG_ECHO,        56'h0123456789ABCD, 32'h0, 4'h0, 1'b1, 1'b0, 64'h0123456789ABCD00},
    '{OP_MSG,   MSG_ECHO,        56'hFFFFFFFFFFFFFF, 32'h0, 4'h0, 1'b1, 1'b0, 64'hFFFFFFFFFFFFFF00},
    '{OP_MSG,   MSG_ECHO,        56'h1,              32'h0, 4'h0, 1'b1, 1'b0, 64'h100},
    '{OP_MSG,   MSG_ECHO,        56'hA5A5A5A5A5A5A5, 32'h0, 4'h0, 1'b1, 1'b0, 64'hA5A5A5A5A5A5A500},
    '{OP_MSG,   MSG_LED_SET,     56'h5,              32'h0, 4'h5, 1'b0, 1'b0, 64'h0},
    '{OP_MSG,   MSG_LED_SET,     56'hFFFFFFFFFFFF0A, 32'h0, 4'hA, 1'b0, 1'b0, 64'h0},
    '{OP_MSG,   MSG_CMD6_STATUS, 56'h0,              32'h0, 4'hA, 1'b1, 1'b1, 64'h0},
    '{OP_BLOCK, 8'h00,           56'h0,              32'h0, 4'hA, 1'b0, 1'b0, 64'h0},
    '{OP_MSG,   MSG_CMD6_STATUS, 56'h0,              32'h0, 4'hA, 1'b1, 1'b1, 64'h0},
    '{OP_BLOCK, 8'h00,           56'h0,       32'h5A5A0001, 4'hA, 1'b0, 1'b0, 64'h0},
    '{OP_MSG,   MSG_CMD6_STATUS, 56'h0,              32'h0, 4'hA, 1'b1, 1'b1, 64'h0},
    '{OP_MSG,   MSG_NOP,         56'h3,              32'h0, 4'hA, 1'b0, 1'b0, 64'h0},
    '{OP_MSG,   8'hC5,           56'h7,              32'h0, 4'hA, 1'b0, 1'b0, 64'h0},
    '{OP_MSG,   MSG_LED_SET,     56'h3,              32'h0, 4'h3, 1'b0, 1'b0, 64'h0},
    '{OP_MSG,   MSG_ECHO,        56'h00C0FFEE000000, 32'h0, 4'h3, 1'b1, 1'b0, 64'h00C0FFEE00000000}
};

`endif

// ==== tb_ice_app.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_ice_app import ice_app_pkg::*; ();

    localparam int          CLK_PERIOD   = 40;
    localparam int          DRIVE_DLY    = 5;      // Inputs change after the edge
    localparam int          RESET_CYCLES = 5;
    localparam int          OE_TIMEOUT   = 20;     // Last message bit to first response bit
    localparam int          QUIET_CYCLES = 16;
    localparam int          BLOCK_WORDS  = 32;
    localparam int          MODE_WORD    = 8;
    localparam logic [31:0] TB_SEED      = 32'hcd6864e1;

    logic           sd_datInWrite_clk = 1'b0;
    logic           sd_datInWrite_rst_;
    logic           spi_data_in;
    logic           spi_data_out;
    logic           spi_data_oe;
    logic           dat_in_start;
    logic           dat_in_trigger;
    sd_word_t       dat_in_data;
    logic [3:0]     led;

    integer         seed;
    access_mode_t   exp_mode;       // Model of the captured CMD6 mode
    logic           exp_mode_valid;

    `include "tb_ice_app_table.svh"

    ice_app #(
        .CMD6_BLOCK_WORDS   (BLOCK_WORDS),
        .CMD6_MODE_WORD     (MODE_WORD)
    ) UUT (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .spi_data_in        (spi_data_in),
        .spi_data_out       (spi_data_out),
        .spi_data_oe        (spi_data_oe),
        .dat_in_start       (dat_in_start),
        .dat_in_trigger     (dat_in_trigger),
        .dat_in_data        (dat_in_data),
        .led                (led)
    );

    always #(CLK_PERIOD / 2) sd_datInWrite_clk = ~sd_datInWrite_clk;

    // ====================
    // Helpers
    // ====================
    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic next_cycle();
        @(posedge sd_datInWrite_clk);
        #DRIVE_DLY;
    endtask

    function automatic resp_t mode_response();
        return {exp_mode, exp_mode_valid, 59'b0};  // Mode in 63..60 and valid in 59
    endfunction

    task automatic send_message(input logic [7:0] mtype, input msg_arg_t arg);
        logic [MSG_LEN-1:0] msg;
        msg = {mtype, arg};
        for (int i = MSG_LEN - 1; i >= 0; i--) begin
            spi_data_in = msg[i];   // Bit 63 goes first as the start bit
            next_cycle();
        end
        spi_data_in = 1'b0;
    endtask

    task automatic receive_response(output resp_t resp);
        int waited;
        waited = 0;
        while (!spi_data_oe) begin
            if (waited == OE_TIMEOUT) begin
                stop_with_error("Timeout: spi_data_oe never went high after a message");
            end
            next_cycle();
            waited++;
        end
        for (int i = RESP_LEN - 1; i >= 0; i--) begin
            assert (spi_data_oe === 1'b1) else
                stop_with_error($sformatf("Fail at %0t ns: spi_data_oe low at response bit %0d",
                                          $time, i));
            resp[i] = spi_data_out;
            next_cycle();
        end
        assert (spi_data_oe === 1'b0) else
            stop_with_error($sformatf("Fail at %0t ns: spi_data_oe high past 64 bits", $time));
    endtask

    task automatic check_quiet();
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            assert (spi_data_oe === 1'b0) else
                stop_with_error($sformatf("Fail at %0t ns: unexpected spi_data_oe", $time));
            next_cycle();
        end
    endtask

    task automatic send_block(input logic [31:0] blk_seed);
        sd_word_t words [BLOCK_WORDS];
        seed = TB_SEED ^ blk_seed;
        dat_in_start = 1'b1;
        next_cycle();
        dat_in_start = 1'b0;
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            words[i]       = sd_word_t'($random(seed));
            dat_in_trigger = 1'b1;
            dat_in_data    = words[i];
            next_cycle();
        end
        dat_in_trigger = 1'b0;
        dat_in_data    = '0;
        // Access mode nibble of the CMD6 status block
        exp_mode       = words[MODE_WORD][11:8];
        exp_mode_valid = 1'b1;
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        resp_t resp;
        resp_t exp_data;

        sd_datInWrite_rst_ = 1'b0;
        spi_data_in        = 1'b0;
        dat_in_start       = 1'b0;
        dat_in_trigger     = 1'b0;
        dat_in_data        = '0;
        seed               = TB_SEED;
        exp_mode           = '0;
        exp_mode_valid     = 1'b0;

        repeat (RESET_CYCLES) @(posedge sd_datInWrite_clk);
        #DRIVE_DLY;
        sd_datInWrite_rst_ = 1'b1;

        assert (led === 4'h0) else
            stop_with_error($sformatf("Fail at %0t ns: led %h after reset", $time, led));
        check_quiet();  // Idle link stays off the line

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (stim_tab[r].op == OP_BLOCK) begin
                send_block(stim_tab[r].blk_seed);
            end else begin
                send_message(stim_tab[r].msg_type, stim_tab[r].arg);
                if (stim_tab[r].exp_resp) begin
                    receive_response(resp);
                    exp_data = stim_tab[r].mode_resp ? mode_response() : stim_tab[r].exp_data;
                    assert (resp === exp_data) else
                        stop_with_error($sformatf("Fail at %0t ns: row %0d response %h, exp %h",
                                                  $time, r, resp, exp_data));
                end else begin
                    check_quiet();
                end
            end
            assert (led === stim_tab[r].exp_led) else
                stop_with_error($sformatf("Fail at %0t ns: row %0d led %h, exp %h",
                                          $time, r, led, stim_tab[r].exp_led));
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ice_app.sv ====
`default_nettype none
`timescale 1ns/1ns

module ice_app import ice_app_pkg::*; #(
    parameter int CMD6_BLOCK_WORDS = 32,    // 512-bit status block in 16-bit words
    parameter int CMD6_MODE_WORD   = 8
) (
    input  logic                    sd_datInWrite_clk,
    input  logic                    sd_datInWrite_rst_,

    // Serial link to host
    input  logic                    spi_data_in,
    output logic                    spi_data_out,
    output logic                    spi_data_oe,

    // SD data-in word stream
    input  logic                    dat_in_start,
    input  logic                    dat_in_trigger,
    input  sd_word_t                dat_in_data,

    output logic [LED_WIDTH-1:0]    led
);

    access_mode_t   access_mode;
    logic           access_mode_valid;

    spi_cmd_if cmd_bus ();

    // ====================
    // Link
    // ====================
    spi_link u_spi_link (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .spi_data_in        (spi_data_in),
        .spi_data_out       (spi_data_out),
        .spi_data_oe        (spi_data_oe),
        .cmd                (cmd_bus.link)
    );

    // ====================
    // Command execution
    // ====================
    cmd_exec u_cmd_exec (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .cmd                (cmd_bus.exec),
        .access_mode        (access_mode),
        .access_mode_valid  (access_mode_valid),
        .led                (led)
    );

    // ====================
    // CMD6 access mode
    // ====================
    cmd6_capture #(
        .CMD6_BLOCK_WORDS   (CMD6_BLOCK_WORDS),
        .CMD6_MODE_WORD     (CMD6_MODE_WORD)
    ) u_cmd6_capture (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .dat_in_start       (dat_in_start),
        .dat_in_trigger     (dat_in_trigger),
        .dat_in_data        (dat_in_data),
        .access_mode        (access_mode),
        .access_mode_valid  (access_mode_valid)
    );

endmodule

`default_nettype wire

// ==== cmd6_capture.sv ====
`default_nettype none
`timescale 1ns/1ns

module cmd6_capture import ice_app_pkg::*; #(
    parameter int CMD6_BLOCK_WORDS = 32,
    parameter int CMD6_MODE_WORD   = 8
) (
    input  logic            sd_datInWrite_clk,
    input  logic            sd_datInWrite_rst_,

    input  logic            dat_in_start,
    input  logic            dat_in_trigger,
    input  sd_word_t        dat_in_data,

    output access_mode_t    access_mode,
    output logic            access_mode_valid
);

    // One extra count so the counter can park past the block
    localparam int CNT_W = $clog2(CMD6_BLOCK_WORDS + 1);

    logic [CNT_W-1:0]   word_cnt;
    logic               in_block;

    assign in_block = (word_cnt < CNT_W'(CMD6_BLOCK_WORDS));

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            word_cnt          <= CNT_W'(CMD6_BLOCK_WORDS);  // No block open yet
            access_mode       <= '0;
            access_mode_valid <= 1'b0;
        end else if (dat_in_start) begin
            word_cnt          <= '0;
            access_mode_valid <= 1'b0;
        end else if (dat_in_trigger && in_block) begin
            word_cnt <= word_cnt + 1'b1;

            if (word_cnt == CNT_W'(CMD6_MODE_WORD)) begin
                access_mode       <= dat_in_data[ACCESS_MODE_LSB +: ACCESS_MODE_LEN];
                access_mode_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cmd_exec.sv ====
`default_nettype none
`timescale 1ns/1ns

module cmd_exec import ice_app_pkg::*; (
    input  logic                    sd_datInWrite_clk,
    input  logic                    sd_datInWrite_rst_,

    spi_cmd_if.exec                 cmd,

    input  access_mode_t            access_mode,
    input  logic                    access_mode_valid,

    output logic [LED_WIDTH-1:0]    led
);

    logic   type_known;
    logic   led_we;
    resp_t  resp_next;

    // ====================
    // Decode
    // ====================
    always_comb begin
        type_known = 1'b1;
        led_we     = 1'b0;
        resp_next  = '0;

        case (cmd.msg_type)
            MSG_ECHO: begin
                resp_next[RESP_ECHO_LSB +: MSG_ARG_LEN] = cmd.msg_arg;
            end

            MSG_LED_SET: begin
                led_we = 1'b1;
            end

            MSG_CMD6_STATUS: begin
                resp_next[RESP_MODE_LSB +: ACCESS_MODE_LEN] = access_mode;
                resp_next[RESP_MODE_VALID_BIT]              = access_mode_valid;
            end

            MSG_NOP: begin
                type_known = 1'b1;  // Accepted, does nothing
            end

            default: begin
                type_known = 1'b0;  // Unknown type is dropped silently
            end
        endcase
    end

    // ====================
    // Execute
    // ====================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            cmd.cmd_done <= 1'b0;
            cmd.resp_en  <= 1'b0;
            led          <= '0;
        end else begin
            cmd.cmd_done <= cmd.msg_valid;  // Always one cycle behind

            if (cmd.msg_valid) begin
                // Response flag lives in the type, trusted only for known types
                cmd.resp_en <= type_known & cmd.msg_type[MSG_RESP_BIT];

                if (led_we) begin
                    led <= cmd.msg_arg[LED_WIDTH-1:0];
                end
            end
        end
    end

    // Response word, sampled by the link on cmd_done
    always_ff @(posedge sd_datInWrite_clk) begin
        if (cmd.msg_valid) begin
            cmd.resp_data <= resp_next;
        end
    end

endmodule

`default_nettype wire

// ==== spi_link.sv ====
`default_nettype none
`timescale 1ns/1ns

module spi_link import ice_app_pkg::*; (
    input  logic        sd_datInWrite_clk,
    input  logic        sd_datInWrite_rst_,

    input  logic        spi_data_in,
    output logic        spi_data_out,
    output logic        spi_data_oe,

    spi_cmd_if.link     cmd
);

    typedef enum logic [1:0] {
        ST_IDLE,        // Waiting for the start bit
        ST_MSG_IN,      // Shifting in bits 62..0
        ST_WAIT_CMD,    // Executor busy
        ST_RESP_OUT     // Shifting out the response
    } link_state_t;

    localparam int CNT_W = $clog2((MSG_LEN > RESP_LEN) ? MSG_LEN : RESP_LEN);

    link_state_t        state;
    logic [CNT_W-1:0]   bit_cnt;    // Index of the bit on the wire
    logic [MSG_LEN-1:0] msg_shift;
    resp_t              resp_shift;

    // ====================
    // Message fields
    // ====================
    assign cmd.msg_type = msg_type_t'(msg_shift[MSG_TYPE_LSB +: MSG_TYPE_LEN]);
    assign cmd.msg_arg  = msg_shift[MSG_ARG_LEN-1:0];

    // MSB of the response register drives the line
    assign spi_data_out = spi_data_oe & resp_shift[RESP_LEN-1];

    // ====================
    // Link state machine
    // ====================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            state         <= ST_IDLE;
            bit_cnt       <= '0;
            spi_data_oe   <= 1'b0;
            cmd.msg_valid <= 1'b0;
        end else begin
            cmd.msg_valid <= 1'b0;

            case (state)
                ST_IDLE: begin
                    // First high sample is message bit 63
                    if (spi_data_in) begin
                        bit_cnt <= CNT_W'(MSG_LEN - 2);
                        state   <= ST_MSG_IN;
                    end
                end

                ST_MSG_IN: begin
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == '0) begin    // Bit 0 sampled at this edge
                        cmd.msg_valid <= 1'b1;
                        state         <= ST_WAIT_CMD;
                    end
                end

                ST_WAIT_CMD: begin
                    if (cmd.cmd_done) begin
                        if (cmd.resp_en) begin
                            bit_cnt     <= CNT_W'(RESP_LEN - 1);
                            spi_data_oe <= 1'b1;
                            state       <= ST_RESP_OUT;
                        end else begin
                            state <= ST_IDLE;   // Nothing to send back
                        end
                    end
                end

                ST_RESP_OUT: begin
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == '0) begin    // Bit 0 done, release the line
                        spi_data_oe <= 1'b0;
                        state       <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // ====================
    // Shift registers
    // ====================
    always_ff @(posedge sd_datInWrite_clk) begin
        case (state)
            ST_IDLE: begin
                if (spi_data_in) begin
                    msg_shift <= {msg_shift[MSG_LEN-2:0], 1'b1};
                end
            end

            ST_MSG_IN: begin
                msg_shift <= {msg_shift[MSG_LEN-2:0], spi_data_in};  // MSB first
            end

            ST_WAIT_CMD: begin
                if (cmd.cmd_done && cmd.resp_en) begin
                    resp_shift <= cmd.resp_data;
                end
            end

            ST_RESP_OUT: begin
                resp_shift <= {resp_shift[RESP_LEN-2:0], 1'b0};
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== spi_cmd_if.sv ====
`default_nettype none
`timescale 1ns/1ns

interface spi_cmd_if import ice_app_pkg::*; ();

    // Link to executor
    logic       msg_valid;  // One-cycle pulse
    msg_type_t  msg_type;
    msg_arg_t   msg_arg;    // Held until the next message

    // Executor to link, all valid with cmd_done
    logic       cmd_done;
    logic       resp_en;
    resp_t      resp_data;

    modport link (
        output msg_valid, msg_type, msg_arg,
        input  cmd_done, resp_en, resp_data
    );

    modport exec (
        input  msg_valid, msg_type, msg_arg,
        output cmd_done, resp_en, resp_data
    );

endinterface

`default_nettype wire

// ==== ice_app_pkg.sv ====
`default_nettype none

package ice_app_pkg;

    // ====================
    // Message framing
    // ====================
    localparam int MSG_LEN      = 64;
    localparam int RESP_LEN     = 64;
    localparam int MSG_TYPE_LEN = 8;                        // Top bits of a message
    localparam int MSG_ARG_LEN  = MSG_LEN - MSG_TYPE_LEN;   // Low 56 bits
    localparam int MSG_TYPE_LSB = MSG_ARG_LEN;
    localparam int MSG_RESP_BIT = 6;                        // Type bit, response follows

    // ====================
    // Field positions
    // ====================
    // Echo returns the argument left aligned, low byte zero
    localparam int RESP_ECHO_LSB       = RESP_LEN - MSG_ARG_LEN;
    localparam int ACCESS_MODE_LEN     = 4;
    localparam int RESP_MODE_LSB       = RESP_LEN - ACCESS_MODE_LEN;   // Bits 63..60
    localparam int RESP_MODE_VALID_BIT = RESP_MODE_LSB - 1;            // Bit 59
    localparam int LED_WIDTH           = 4;

    // SD data-in word and the CMD6 access-mode nibble within it
    localparam int SD_WORD_LEN     = 16;
    localparam int ACCESS_MODE_LSB = 8;                     // Bits 11..8

    // ====================
    // Types
    // ====================
    // Bit 7 of every type is high, doubles as the start bit on the link
    typedef enum logic [MSG_TYPE_LEN-1:0] {
        MSG_NOP         = 8'h80,
        MSG_LED_SET     = 8'h81,
        MSG_ECHO        = 8'hC0,
        MSG_CMD6_STATUS = 8'hC2
    } msg_type_t;

    typedef logic [MSG_ARG_LEN-1:0]     msg_arg_t;
    typedef logic [RESP_LEN-1:0]        resp_t;
    typedef logic [SD_WORD_LEN-1:0]     sd_word_t;
    typedef logic [ACCESS_MODE_LEN-1:0] access_mode_t;

endpackage

`default_nettype wire
